//--- Bender.yml
package:
  name: stage2_cnn_core

sources:
  # packages first, then blocks, then the top level
  - files:
      - common/stage2_geom_pkg.sv
      - common/stage2_link_pkg.sv
      - verilog/stage2_bias_relu.sv
      - stage2_pooling/stage2_pooling.sv
      - verilog/stage2_result_fifo.sv
      - verilog/stage2_host_link.sv
      - verilog/stage2_cnn_core.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_stage2_cnn_core.sv

//--- common/stage2_geom_pkg.sv
`default_nettype none

package stage2_geom_pkg;

    // ==================================================
    // frame geometry
    // ==================================================

    // input feature map, one partial sum per pixel
    localparam int POOL_COL = 24;
    localparam int POOL_ROW = 24;
    // 2x2 window, stride 2
    localparam int OUT_COL  = 12;

    // pixel and window counters
    localparam int COL_W  = $clog2(POOL_COL);
    localparam int ROW_W  = $clog2(POOL_ROW);
    localparam int OCOL_W = $clog2(OUT_COL);

    // ==================================================
    // data widths
    // ==================================================

    localparam int PSUM_W = 24;
    localparam int BIAS_W = 16;
    localparam int ACT_W  = 19;
    // one guard bit above the wider operand, bias add never wraps
    localparam int SUM_W  = ((PSUM_W > BIAS_W) ? PSUM_W : BIAS_W) + 1;

    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic signed [BIAS_W-1:0] bias_t;
    typedef logic        [ACT_W-1:0]  act_t;

    // saturation ceiling, full unsigned range of an activation
    localparam act_t ACT_MAX = '1;

    // activation stream, bias stage to pooling
    typedef struct packed {
        logic valid;
        act_t act;
    } act_beat_t;

endpackage

`default_nettype wire

//--- common/stage2_link_pkg.sv
`default_nettype none

package stage2_link_pkg;

    import stage2_geom_pkg::*;

    // ==================================================
    // pooled result, fifo entry and host word
    // ==================================================

    typedef struct packed {
        act_t value;
        // last of the 144 windows in a frame
        logic frame_last;
    } pool_result_t;

    // result fifo sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    // occupancy needs one more bit than the pointers
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

    // free entries needed before a new pixel is taken
    // bias reg + pooling reg + write on the same edge
    localparam int RDY_MARGIN = 3;

endpackage

`default_nettype wire

//--- stage2_cnn_core.f
+incdir+test
common/stage2_geom_pkg.sv
common/stage2_link_pkg.sv
verilog/stage2_bias_relu.sv
stage2_pooling/stage2_pooling.sv
verilog/stage2_result_fifo.sv
verilog/stage2_host_link.sv
verilog/stage2_cnn_core.sv
test/tb_stage2_cnn_core.sv

//--- stage2_pooling/stage2_pooling.sv
`timescale 1ns/10ps
`default_nettype none

module stage2_pooling
    import stage2_geom_pkg::*;
    import stage2_link_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire act_beat_t  i_act,
    output logic            o_pool_valid,
    output pool_result_t    o_pool
);

    // larger of two activations
    function automatic act_t act_max(input act_t a, input act_t b);
        act_max = (a > b) ? a : b;
    endfunction

    // ==================================================
    // row and column counters
    // ==================================================

    logic [COL_W-1:0] r_col;
    logic [ROW_W-1:0] r_row;
    logic             w_col_last;
    logic             w_row_last;

    assign w_col_last = (r_col == COL_W'(POOL_COL - 1));
    assign w_row_last = (r_row == ROW_W'(POOL_ROW - 1));

    // move only on valid beats so gaps keep window alignment
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_col <= '0;
            r_row <= '0;
        end else if (i_act.valid) begin
            if (w_col_last) begin
                r_col <= '0;
                if (w_row_last) begin
                    r_row <= '0;
                end else begin
                    r_row <= r_row + 1'b1;
                end
            end else begin
                r_col <= r_col + 1'b1;
            end
        end
    end

    // ==================================================
    // held pixel and half-row buffer
    // ==================================================

    act_t              r_hold;
    act_t              r_pair_buf [OUT_COL];
    logic [OCOL_W-1:0] w_pair_idx;
    act_t              w_pair_max;
    logic              w_even_row_close;
    logic              w_odd_row_close;

    // window index along the row
    assign w_pair_idx = r_col[COL_W-1:1];

    // left pixel of the pair and the current pixel
    assign w_pair_max = act_max(r_hold, i_act.act);

    // odd column closes a pair, row parity picks store or pool
    assign w_even_row_close = i_act.valid && r_col[0] && !r_row[0];
    assign w_odd_row_close  = i_act.valid && r_col[0] && r_row[0];

    always_ff @(posedge clk) begin
        // left pixel of each pair, both row parities
        if (i_act.valid && !r_col[0]) begin
            r_hold <= i_act.act;
        end
        // top row of the window, kept until the row below
        if (w_even_row_close) begin
            r_pair_buf[w_pair_idx] <= w_pair_max;
        end
    end

    // ==================================================
    // 2x2 window max
    // ==================================================

    logic         r_pool_valid;
    pool_result_t r_pool;

    // valid one cycle after the beat that closes the window
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_pool_valid <= 1'b0;
        end else begin
            r_pool_valid <= w_odd_row_close;
        end
    end

    always_ff @(posedge clk) begin
        if (w_odd_row_close) begin
            // top pair max against the bottom pair
            r_pool.value      <= act_max(r_pair_buf[w_pair_idx], w_pair_max);
            // bottom right window of the frame
            r_pool.frame_last <= w_row_last && w_col_last;
        end
    end

    assign o_pool_valid = r_pool_valid;
    assign o_pool       = r_pool;

endmodule

`default_nettype wire

//--- test/tb_stage2_util.svh
`ifndef TB_STAGE2_UTIL_SVH
`define TB_STAGE2_UTIL_SVH

// ==================================================
// random source
// ==================================================

// galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
// lsb is the output bit of each step
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        lfsr_step = (state >> 1) ^ 32'h8020_0003;
    end else begin
        lfsr_step = state >> 1;
    end
endfunction

// ==================================================
// reference model
// ==================================================

// psum + bias, negative to zero, clamp at the activation ceiling
function automatic act_t act_ref(input psum_t psum, input bias_t bias);
    longint sum;
    // 64-bit add, cannot wrap
    sum = longint'(psum) + longint'(bias);
    if (sum < 0) begin
        act_ref = '0;
    end else if (sum > longint'(ACT_MAX)) begin
        act_ref = ACT_MAX;
    end else begin
        act_ref = act_t'(sum);
    end
endfunction

// largest of the four pixels of one window
function automatic act_t window_max(input act_t a, input act_t b, input act_t c, input act_t d);
    act_t m;
    m = a;
    if (b > m) m = b;
    if (c > m) m = c;
    if (d > m) m = d;
    window_max = m;
endfunction

`endif

//--- test/tb_stage2_cnn_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_stage2_cnn_core
    import stage2_geom_pkg::*;
    import stage2_link_pkg::*;
();

    localparam int          FRAMES        = 4;
    localparam int          PIX_PER_FRAME = POOL_COL * POOL_ROW;
    localparam int          WIN_PER_FRAME = PIX_PER_FRAME / 4;
    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYC     = 8;
    // slowest host plus idle input per accepted pixel
    localparam int          CYC_PER_PIX   = 10;
    localparam int          TIMEOUT_CYC   = RESET_CYC + FRAMES * PIX_PER_FRAME * CYC_PER_PIX + 100;
    // pop to req rise in the link, plus slack
    localparam int          DRAIN_CYC     = 4;
    localparam logic [31:0] SEED          = 32'hc07f53c8;

    logic         clk;
    logic         reset_n;
    logic         i_in_valid;
    psum_t        i_in_psum;
    bias_t        i_bias;
    logic         o_in_ready;
    logic         o_req;
    pool_result_t o_result;
    logic         i_ack;

    // model and stimulus state
    logic [31:0]  lfsr_state;
    pool_result_t exp_q [$];
    act_t         frame_act [POOL_ROW][POOL_COL];
    int           m_row;
    int           m_col;
    int           n_xfer;
    int           n_checked;
    int           bias_frame;
    int           ack_phase;
    int           ack_cnt;
    logic         pending_xfer;
    logic         prev_req;
    pool_result_t prev_result;
    logic         ready_low_seen;
    logic         saw_zero;
    logic         saw_max;

    `include "tb_stage2_util.svh"

    stage2_cnn_core i_stage2_cnn_core (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_psum  (i_in_psum),
        .i_bias     (i_bias),
        .o_in_ready (o_in_ready),
        .o_req      (o_req),
        .o_result   (o_result),
        .i_ack      (i_ack)
    );

    // ==================================================
    // helpers
    // ==================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // n fresh bits with one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        rand_bits = v;
    endfunction

    // pixel taken on the last rising edge while the inputs still hold it
    task automatic model_accept();
        pool_result_t exp_res;
        frame_act[m_row][m_col] = act_ref(i_in_psum, i_bias);
        // odd row and odd column close a window
        if ((m_row % 2 == 1) && (m_col % 2 == 1)) begin
            exp_res.value = window_max(frame_act[m_row-1][m_col-1], frame_act[m_row-1][m_col],
                                       frame_act[m_row][m_col-1], frame_act[m_row][m_col]);
            exp_res.frame_last = (m_row == POOL_ROW - 1) && (m_col == POOL_COL - 1);
            exp_q.push_back(exp_res);
        end
        m_col = (m_col == POOL_COL - 1) ? 0 : m_col + 1;
        if (m_col == 0) begin
            m_row = (m_row == POOL_ROW - 1) ? 0 : m_row + 1;
        end
        n_xfer++;
    endtask

    // new beat only after the old one was taken
    task automatic drive_input();
        logic [1:0]  mode;
        logic [19:0] low;
        if (!i_in_valid || pending_xfer) begin
            if (n_xfer == FRAMES * PIX_PER_FRAME) begin
                i_in_valid = 1'b0;
            end else begin
                // bias fixed for a whole frame
                if (n_xfer / PIX_PER_FRAME != bias_frame) begin
                    bias_frame = n_xfer / PIX_PER_FRAME;
                    i_bias     = bias_t'(rand_bits(BIAS_W));
                end
                i_in_valid = (rand_bits(2) != 2'd0);
                mode = 2'(rand_bits(2));
                low  = 20'(rand_bits(20));
                case (mode)
                    2'd0:    i_in_psum = psum_t'(rand_bits(PSUM_W));
                    // large positive that saturates
                    2'd1:    i_in_psum = {4'b0111, low};
                    // large negative that relu clears
                    2'd2:    i_in_psum = {4'b1000, low};
                    // near the activation range
                    default: i_in_psum = psum_t'($signed(low));
                endcase
            end
        end
    endtask

    // four-phase protocol seen from the host side
    task automatic check_link();
        if (o_req && !prev_req) begin
            assert (!i_ack) else abort_run("o_req rose while i_ack was still high");
        end
        if (o_req && prev_req) begin
            assert (o_result == prev_result) else
                abort_run($sformatf(
                    "FAILED at %0t: o_result changed from %h to %h while o_req high",
                    $time, prev_result, o_result));
        end
        if (!o_in_ready) ready_low_seen = 1'b1;
        prev_req    = o_req;
        prev_result = o_result;
    endtask

    // random ack delays with a compare on every ack rise
    task automatic respond_host();
        pool_result_t exp_res;
        if (ack_phase == 0 && o_req) begin
            ack_cnt   = int'(rand_bits(3));
            ack_phase = 1;
        end
        if (ack_phase == 1) begin
            if (ack_cnt == 0) begin
                assert (exp_q.size() > 0) else abort_run("host got a result with none expected");
                exp_res = exp_q.pop_front();
                assert (o_result == exp_res) else
                    abort_run($sformatf(
                        "FAILED at %0t: result %0d value %0d last %0b, expected %0d last %0b",
                        $time, n_checked, o_result.value, o_result.frame_last,
                        exp_res.value, exp_res.frame_last));
                assert (o_result.frame_last == (n_checked % WIN_PER_FRAME == WIN_PER_FRAME - 1))
                else
                    abort_run($sformatf(
                        "FAILED at %0t: frame_last %0b on result %0d of the frame",
                        $time, o_result.frame_last, n_checked % WIN_PER_FRAME));
                if (exp_res.value == '0) saw_zero = 1'b1;
                if (exp_res.value == ACT_MAX) saw_max = 1'b1;
                n_checked++;
                i_ack     = 1'b1;
                ack_phase = 2;
            end else begin
                ack_cnt--;
            end
        end
        if (ack_phase == 2 && !o_req) begin
            ack_cnt   = int'(rand_bits(3));
            ack_phase = 3;
        end
        if (ack_phase == 3) begin
            if (ack_cnt == 0) begin
                i_ack     = 1'b0;
                ack_phase = 0;
            end else begin
                ack_cnt--;
            end
        end
    endtask

    // ==================================================
    // clock, watchdog, main sequence
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        abort_run("timeout: the run did not finish in the expected number of cycles");
    end

    initial begin
        reset_n        = 1'b0;
        i_in_valid     = 1'b0;
        i_in_psum      = '0;
        i_bias         = '0;
        i_ack          = 1'b0;
        lfsr_state     = SEED;
        m_row          = 0;
        m_col          = 0;
        n_xfer         = 0;
        n_checked      = 0;
        bias_frame     = -1;
        ack_phase      = 0;
        ack_cnt        = 0;
        pending_xfer   = 1'b0;
        prev_req       = 1'b0;
        prev_result    = '0;
        ready_low_seen = 1'b0;
        saw_zero       = 1'b0;
        saw_max        = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        reset_n = 1'b1;
        assert (!o_req && o_in_ready) else
            abort_run($sformatf("FAILED at %0t: o_req %0b o_in_ready %0b after reset",
                                $time, o_req, o_in_ready));

        // all driving and sampling on the falling edge
        while (n_checked < FRAMES * WIN_PER_FRAME || ack_phase != 0) begin
            @(negedge clk);
            if (pending_xfer) model_accept();
            check_link();
            drive_input();
            // ready is stable until the next rising edge
            pending_xfer = i_in_valid && o_in_ready;
            respond_host();
        end

        // a further result would raise o_req within the link's setup delay
        repeat (DRAIN_CYC) begin
            @(negedge clk);
            assert (!o_req) else abort_run("the DUT sent a result after the last expected one");
        end
        assert (ready_low_seen) else abort_run("o_in_ready never fell during the run");
        assert (saw_zero && saw_max) else abort_run("no window hit zero or the saturation ceiling");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/stage2_bias_relu.sv
`timescale 1ns/10ps
`default_nettype none

module stage2_bias_relu
    import stage2_geom_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    // accepted beats only, valid already gated with ready
    input  wire logic      i_in_valid,
    input  wire psum_t     i_in_psum,
    input  wire bias_t     i_bias,
    output act_beat_t      o_act
);

    // ==================================================
    // bias add and clamp
    // ==================================================

    logic signed [SUM_W-1:0] w_sum;
    act_t                    w_act;
    logic                    r_valid;
    act_t                    r_act;

    // both operands sign extended to the guard width
    assign w_sum = SUM_W'(i_in_psum) + SUM_W'(i_bias);

    always_comb begin
        if (w_sum < 0) begin
            // relu
            w_act = '0;
        end else if (w_sum > $signed(SUM_W'(ACT_MAX))) begin
            // saturate at the top of the activation range
            w_act = ACT_MAX;
        end else begin
            w_act = w_sum[ACT_W-1:0];
        end
    end

    // ==================================================
    // output register, one cycle after the transfer
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_in_valid;
        end
    end

    // activation only loads on a beat
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            r_act <= w_act;
        end
    end

    assign o_act = '{valid: r_valid, act: r_act};

endmodule

`default_nettype wire

//--- verilog/stage2_cnn_core.sv
`timescale 1ns/10ps
`default_nettype none

module stage2_cnn_core
    import stage2_geom_pkg::*;
    import stage2_link_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset_n,
    input  wire logic          i_in_valid,
    input  wire psum_t         i_in_psum,
    input  wire bias_t         i_bias,
    output logic               o_in_ready,
    output logic               o_req,
    output pool_result_t       o_result,
    input  wire logic          i_ack
);

    // ==================================================
    // pipeline wiring
    // ==================================================

    logic         w_in_fire;
    act_beat_t    w_act;
    logic         w_pool_valid;
    pool_result_t w_pool;
    pool_result_t w_rd_data;
    logic         w_rd_empty;
    logic         w_rd_pop;

    // accepted input transfer
    assign w_in_fire = i_in_valid && o_in_ready;

    // psum + bias, relu, saturate
    stage2_bias_relu i_stage2_bias_relu (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (w_in_fire),
        .i_in_psum  (i_in_psum),
        .i_bias     (i_bias),
        .o_act      (w_act)
    );

    // 2x2 stride 2 max pool
    stage2_pooling i_stage2_pooling (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_act        (w_act),
        .o_pool_valid (w_pool_valid),
        .o_pool       (w_pool)
    );

    // result buffer, also the source of input ready
    stage2_result_fifo i_stage2_result_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_wr_valid (w_pool_valid),
        .i_wr_data  (w_pool),
        .i_rd_pop   (w_rd_pop),
        .o_rd_data  (w_rd_data),
        .o_rd_empty (w_rd_empty),
        .o_in_ready (o_in_ready)
    );

    // req/ack handoff to the host
    stage2_host_link i_stage2_host_link (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_rd_data  (w_rd_data),
        .i_rd_empty (w_rd_empty),
        .o_rd_pop   (w_rd_pop),
        .o_req      (o_req),
        .o_result   (o_result),
        .i_ack      (i_ack)
    );

endmodule

`default_nettype wire

//--- verilog/stage2_host_link.sv
`timescale 1ns/10ps
`default_nettype none

module stage2_host_link
    import stage2_link_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset_n,
    input  wire pool_result_t  i_rd_data,
    input  wire logic          i_rd_empty,
    output logic               o_rd_pop,
    output logic               o_req,
    output pool_result_t       o_result,
    input  wire logic          i_ack
);

    // ==================================================
    // four-phase sender
    // ==================================================

    // setup gives o_result a cycle before req rises
    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,
        S_REQ,
        S_ACK_LOW
    } link_state_t;

    link_state_t  r_state;
    pool_result_t r_result;

    // take the head when idle, ack is already low here
    assign o_rd_pop = (r_state == S_IDLE) && !i_rd_empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_state <= S_IDLE;
        end else begin
            case (r_state)
                S_IDLE:    if (o_rd_pop) r_state <= S_SETUP;
                S_SETUP:   r_state <= S_REQ;
                // req held until the host acks
                S_REQ:     if (i_ack) r_state <= S_ACK_LOW;
                // req dropped, wait for the host to release ack
                S_ACK_LOW: if (!i_ack) r_state <= S_IDLE;
                default:   r_state <= S_IDLE;
            endcase
        end
    end

    // result stays put until the next pop
    always_ff @(posedge clk) begin
        if (o_rd_pop) begin
            r_result <= i_rd_data;
        end
    end

    assign o_req    = (r_state == S_REQ);
    assign o_result = r_result;

endmodule

`default_nettype wire

//--- verilog/stage2_result_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module stage2_result_fifo
    import stage2_link_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset_n,
    input  wire logic          i_wr_valid,
    input  wire pool_result_t  i_wr_data,
    input  wire logic          i_rd_pop,
    output pool_result_t       o_rd_data,
    output logic               o_rd_empty,
    output logic               o_in_ready
);

    // ==================================================
    // storage and pointers
    // ==================================================

    pool_result_t       r_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] r_wr_ptr;
    logic [FIFO_AW-1:0] r_rd_ptr;
    logic [FIFO_CW-1:0] r_count;
    logic [FIFO_CW-1:0] w_free;

    // next slot with wrap at the depth
    function automatic logic [FIFO_AW-1:0] ptr_next(input logic [FIFO_AW-1:0] ptr);
        if (ptr == FIFO_AW'(FIFO_DEPTH - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = ptr + 1'b1;
        end
    endfunction

    always_ff @(posedge clk) begin
        if (i_wr_valid) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (i_wr_valid) begin
                r_wr_ptr <= ptr_next(r_wr_ptr);
            end
            // pop only comes from the host link with data present
            if (i_rd_pop) begin
                r_rd_ptr <= ptr_next(r_rd_ptr);
            end
            // push and pop together leave the count alone
            case ({i_wr_valid, i_rd_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    // ==================================================
    // status
    // ==================================================

    assign w_free     = FIFO_CW'(FIFO_DEPTH) - r_count;
    assign o_rd_data  = r_mem[r_rd_ptr];
    assign o_rd_empty = (r_count == '0);
    // room left for everything still in the pipeline
    assign o_in_ready = (w_free >= FIFO_CW'(RDY_MARGIN));

endmodule

`default_nettype wire
